/* source/fpu_pkg.sv */
package fpu_pkg;

    // ----------------------------------------------------------------------
    // Widths
    // ----------------------------------------------------------------------
    localparam int unsigned FLEN          = 32; // Scalar FP32 only
    localparam int unsigned TRANS_ID_BITS = 3;
    localparam int unsigned STATUS_BITS   = 5;  // NV DZ OF UF NX
    localparam int unsigned CLASS_BITS    = 10; // RISC-V fclass mask
    localparam int unsigned EXP_BITS      = 8;
    localparam int unsigned MAN_BITS      = 23;
    localparam int unsigned PIPE_DEPTH    = 2;  // Register stages in the unit

    typedef logic [FLEN-1:0]          fp_word_t;
    typedef logic [TRANS_ID_BITS-1:0] trans_id_t;
    typedef logic [STATUS_BITS-1:0]   fp_status_t;
    typedef logic [2:0]               rm_t;       // Carries the op variant here
    typedef logic [CLASS_BITS-1:0]    fp_class_t;

    // Flag position inside fp_status_t
    localparam int unsigned STATUS_NV = 4;      // Invalid operation, MSB

    // Class mask bit positions, RISC-V order
    localparam int unsigned CLS_NEG_INF  = 0;
    localparam int unsigned CLS_NEG_NORM = 1;
    localparam int unsigned CLS_NEG_SUB  = 2;
    localparam int unsigned CLS_NEG_ZERO = 3;
    localparam int unsigned CLS_POS_ZERO = 4;
    localparam int unsigned CLS_POS_SUB  = 5;
    localparam int unsigned CLS_POS_NORM = 6;
    localparam int unsigned CLS_POS_INF  = 7;
    localparam int unsigned CLS_SNAN     = 8;
    localparam int unsigned CLS_QNAN     = 9;

    localparam fp_word_t CANON_NAN = 32'h7fc00000; // Canonical quiet NaN

    // ----------------------------------------------------------------------
    // Operator encodings
    // ----------------------------------------------------------------------
    // Core side operators, non-computational subset
    typedef enum logic [2:0] {
        FSGNJ    = 3'd0,
        FMIN_MAX = 3'd1,
        FCMP     = 3'd2,
        FCLASS   = 3'd3,
        FMV_F2X  = 3'd4,
        FMV_X2F  = 3'd5
    } fu_op_e;

    // Unit side operations, variant already folded in
    typedef enum logic [3:0] {
        SGNJ     = 4'd0,
        SGNJN    = 4'd1,
        SGNJX    = 4'd2,
        PASS     = 4'd3,
        MIN      = 4'd4,
        MAX      = 4'd5,
        CMP_LE   = 4'd6,
        CMP_LT   = 4'd7,
        CMP_EQ   = 4'd8,
        CLASSIFY = 4'd9
    } nc_op_e;

endpackage

/* source/fp_op_decode.sv */
module fp_op_decode (
    input  fpu_pkg::fu_op_e operator_i, // Core operator
    input  fpu_pkg::rm_t    fpu_rm_i,   // Variant select in bits [1:0]
    output fpu_pkg::nc_op_e nc_op_o     // Unit operation
);

    // ----------------------------------------------------------------------
    // Operator translation
    // ----------------------------------------------------------------------
    // rm bit 2 carries no meaning for FP32 only
    always_comb begin : op_translation
        nc_op_o = fpu_pkg::PASS; // Safe fallback for anything unknown

        unique case (operator_i)
            // Sign injection, variant in rm
            fpu_pkg::FSGNJ: begin
                unique case (fpu_rm_i[1:0])
                    2'b00:   nc_op_o = fpu_pkg::SGNJ;
                    2'b01:   nc_op_o = fpu_pkg::SGNJN;
                    2'b10:   nc_op_o = fpu_pkg::SGNJX;
                    default: nc_op_o = fpu_pkg::PASS; // Illegal rm
                endcase
            end

            // Min or max, variant in rm
            fpu_pkg::FMIN_MAX: begin
                unique case (fpu_rm_i[1:0])
                    2'b00:   nc_op_o = fpu_pkg::MIN;
                    2'b01:   nc_op_o = fpu_pkg::MAX;
                    default: nc_op_o = fpu_pkg::PASS;
                endcase
            end

            // Comparisons le / lt / eq
            fpu_pkg::FCMP: begin
                unique case (fpu_rm_i[1:0])
                    2'b00:   nc_op_o = fpu_pkg::CMP_LE;
                    2'b01:   nc_op_o = fpu_pkg::CMP_LT;
                    2'b10:   nc_op_o = fpu_pkg::CMP_EQ;
                    default: nc_op_o = fpu_pkg::PASS;
                endcase
            end

            fpu_pkg::FCLASS: nc_op_o = fpu_pkg::CLASSIFY; // rm don't care

            // Moves need no recoding, bits go straight through
            fpu_pkg::FMV_F2X,
            fpu_pkg::FMV_X2F: nc_op_o = fpu_pkg::PASS;

            default: nc_op_o = fpu_pkg::PASS;
        endcase
    end

endmodule

/* source/fp_issue_hold.sv */
module fp_issue_hold (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                flush_i,
    // Issue side, inverted protocol
    input  logic                fpu_valid_i,   // One cycle pulse per op
    output logic                fpu_ready_o,
    input  fpu_pkg::nc_op_e     nc_op_i,
    input  fpu_pkg::fp_word_t   operand_a_i,
    input  fpu_pkg::fp_word_t   operand_b_i,
    input  fpu_pkg::trans_id_t  trans_id_i,
    // Unit side, valid / ready
    input  logic                issue_ready_i,
    output logic                issue_valid_o,
    output fpu_pkg::nc_op_e     nc_op_o,
    output fpu_pkg::fp_word_t   operand_a_o,
    output fpu_pkg::fp_word_t   operand_b_o,
    output fpu_pkg::trans_id_t  tag_o
);

    typedef enum logic {READY, STALL} state_e;

    state_e state_q, state_d;

    logic hold_en;  // Capture incoming op into hold reg
    logic use_hold; // Feed the unit from hold reg

    // Hold register, one decoded op
    fpu_pkg::nc_op_e    nc_op_q;
    fpu_pkg::fp_word_t  operand_a_q;
    fpu_pkg::fp_word_t  operand_b_q;
    fpu_pkg::trans_id_t tag_q;

    // ----------------------------------------------------------------------
    // Protocol inversion FSM
    // ----------------------------------------------------------------------
    always_comb begin : issue_fsm
        fpu_ready_o   = 1'b0;
        issue_valid_o = 1'b0;
        hold_en       = 1'b0;
        use_hold      = 1'b0;
        state_d       = state_q;

        unique case (state_q)
            READY: begin
                fpu_ready_o   = 1'b1;        // Looks ready to the core
                issue_valid_o = fpu_valid_i; // Pulse goes straight to unit
                // Unit busy, park the op and block further issue
                if (fpu_valid_i && !issue_ready_i) begin
                    fpu_ready_o = 1'b0;
                    hold_en     = 1'b1;
                    state_d     = STALL;
                end
            end
            STALL: begin
                issue_valid_o = 1'b1; // Held op pending
                use_hold      = 1'b1;
                if (issue_ready_i) begin
                    fpu_ready_o = 1'b1;  // Taken this cycle, reopen
                    state_d     = READY;
                end
            end
            default: state_d = READY;
        endcase

        if (flush_i) state_d = READY; // Drops a held op too
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin : hold_reg
        if (!rst_ni) begin
            state_q     <= READY;
            nc_op_q     <= fpu_pkg::PASS;
            operand_a_q <= '0;
            operand_b_q <= '0;
            tag_q       <= '0;
        end else begin
            state_q <= state_d;
            if (hold_en) begin
                nc_op_q     <= nc_op_i;
                operand_a_q <= operand_a_i;
                operand_b_q <= operand_b_i;
                tag_q       <= trans_id_i;
            end
        end
    end

    // Direct or held data toward the unit
    assign nc_op_o     = use_hold ? nc_op_q     : nc_op_i;
    assign operand_a_o = use_hold ? operand_a_q : operand_a_i;
    assign operand_b_o = use_hold ? operand_b_q : operand_b_i;
    assign tag_o       = use_hold ? tag_q       : trans_id_i;

endmodule

/* source/fp_operand_class.sv */
module fp_operand_class (
    input  fpu_pkg::fp_word_t  operand_i,
    output fpu_pkg::fp_class_t class_o    // One-hot class mask
);

    logic                         sign;
    logic [fpu_pkg::EXP_BITS-1:0] exponent;
    logic [fpu_pkg::MAN_BITS-1:0] mantissa;
    logic                         exp_ones;  // Inf or NaN
    logic                         exp_zero;  // Zero or subnormal
    logic                         man_zero;

    // Field split
    assign sign     = operand_i[fpu_pkg::FLEN-1];
    assign exponent = operand_i[fpu_pkg::MAN_BITS +: fpu_pkg::EXP_BITS];
    assign mantissa = operand_i[fpu_pkg::MAN_BITS-1:0];

    assign exp_ones = &exponent;
    assign exp_zero = ~|exponent;
    assign man_zero = ~|mantissa;

    always_comb begin : classify
        class_o = '0;
        if (exp_ones && !man_zero) begin
            // Quiet bit is the mantissa MSB, sign ignored
            if (mantissa[fpu_pkg::MAN_BITS-1]) class_o[fpu_pkg::CLS_QNAN] = 1'b1;
            else                               class_o[fpu_pkg::CLS_SNAN] = 1'b1;
        end else if (exp_ones) begin
            if (sign) class_o[fpu_pkg::CLS_NEG_INF] = 1'b1;
            else      class_o[fpu_pkg::CLS_POS_INF] = 1'b1;
        end else if (exp_zero && man_zero) begin
            if (sign) class_o[fpu_pkg::CLS_NEG_ZERO] = 1'b1;
            else      class_o[fpu_pkg::CLS_POS_ZERO] = 1'b1;
        end else if (exp_zero) begin
            // Denormal, no hidden one
            if (sign) class_o[fpu_pkg::CLS_NEG_SUB] = 1'b1;
            else      class_o[fpu_pkg::CLS_POS_SUB] = 1'b1;
        end else begin
            if (sign) class_o[fpu_pkg::CLS_NEG_NORM] = 1'b1;
            else      class_o[fpu_pkg::CLS_POS_NORM] = 1'b1;
        end
    end

endmodule

/* source/fp_noncomp_pipe.sv */
module fp_noncomp_pipe (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 flush_i,
    // Issue side
    input  logic                 issue_valid_i,
    output logic                 issue_ready_o,
    input  fpu_pkg::nc_op_e      nc_op_i,
    input  fpu_pkg::fp_word_t    operand_a_i,
    input  fpu_pkg::fp_word_t    operand_b_i,
    input  fpu_pkg::trans_id_t   tag_i,
    // Writeback side
    input  logic                 fpu_ready_i,
    output logic                 fpu_valid_o,
    output fpu_pkg::fp_word_t    result_o,
    output fpu_pkg::trans_id_t   fpu_trans_id_o,
    output fpu_pkg::fp_status_t  fpu_status_o
);

    localparam int unsigned SB = fpu_pkg::FLEN - 1; // Sign bit

    logic [fpu_pkg::PIPE_DEPTH-1:0] valid_q; // One bit per stage
    logic                           stall;   // Whole pipe frozen

    fpu_pkg::fp_class_t cls_a, cls_b;

    // Stage 1 payload
    fpu_pkg::nc_op_e    s1_op_q;
    fpu_pkg::fp_word_t  s1_a_q, s1_b_q;
    fpu_pkg::fp_class_t s1_cls_a_q, s1_cls_b_q;
    fpu_pkg::trans_id_t s1_tag_q;

    // Stage 2 payload
    fpu_pkg::fp_word_t   s2_res_q;
    fpu_pkg::fp_status_t s2_status_q;
    fpu_pkg::trans_id_t  s2_tag_q;

    fpu_pkg::fp_word_t   res_d;
    fpu_pkg::fp_status_t status_d;
    logic a_nan, b_nan, any_nan, any_snan, both_zero;
    logic a_lt_b;   // Total order, -0 below +0
    logic cmp_lt, cmp_eq;

    assign stall         = fpu_valid_o && !fpu_ready_i; // Result not taken
    assign issue_ready_o = !stall;

    fp_operand_class u_class_a (.operand_i(operand_a_i), .class_o(cls_a));
    fp_operand_class u_class_b (.operand_i(operand_b_i), .class_o(cls_b));

    // ----------------------------------------------------------------------
    // Operation logic, works on stage 1 contents
    // ----------------------------------------------------------------------
    assign a_nan     = s1_cls_a_q[fpu_pkg::CLS_SNAN] | s1_cls_a_q[fpu_pkg::CLS_QNAN];
    assign b_nan     = s1_cls_b_q[fpu_pkg::CLS_SNAN] | s1_cls_b_q[fpu_pkg::CLS_QNAN];
    assign any_nan   = a_nan | b_nan;
    assign any_snan  = s1_cls_a_q[fpu_pkg::CLS_SNAN] | s1_cls_b_q[fpu_pkg::CLS_SNAN];
    assign both_zero = (s1_cls_a_q[fpu_pkg::CLS_NEG_ZERO] | s1_cls_a_q[fpu_pkg::CLS_POS_ZERO])
                     & (s1_cls_b_q[fpu_pkg::CLS_NEG_ZERO] | s1_cls_b_q[fpu_pkg::CLS_POS_ZERO]);

    always_comb begin : order
        if (s1_a_q[SB] != s1_b_q[SB]) a_lt_b = s1_a_q[SB];              // Negative wins
        else if (s1_a_q[SB])          a_lt_b = s1_a_q[SB-1:0] > s1_b_q[SB-1:0];
        else                          a_lt_b = s1_a_q[SB-1:0] < s1_b_q[SB-1:0];
    end

    // IEEE compare treats both zeros as equal
    assign cmp_eq = (s1_a_q == s1_b_q) | both_zero;
    assign cmp_lt = a_lt_b & ~both_zero;

    always_comb begin : execute
        res_d    = s1_a_q;
        status_d = '0;
        unique case (s1_op_q)
            fpu_pkg::SGNJ:  res_d = {s1_b_q[SB], s1_a_q[SB-1:0]};
            fpu_pkg::SGNJN: res_d = {~s1_b_q[SB], s1_a_q[SB-1:0]};
            fpu_pkg::SGNJX: res_d = {s1_a_q[SB] ^ s1_b_q[SB], s1_a_q[SB-1:0]};
            fpu_pkg::PASS:  res_d = s1_a_q;
            fpu_pkg::MIN, fpu_pkg::MAX: begin
                if (a_nan && b_nan) res_d = fpu_pkg::CANON_NAN;
                else if (a_nan)     res_d = s1_b_q;  // Take the number
                else if (b_nan)     res_d = s1_a_q;
                else if (s1_op_q == fpu_pkg::MIN) res_d = a_lt_b ? s1_a_q : s1_b_q;
                else                res_d = a_lt_b ? s1_b_q : s1_a_q;
                status_d[fpu_pkg::STATUS_NV] = any_snan;
            end
            fpu_pkg::CMP_LE: begin
                res_d = {{SB{1'b0}}, ~any_nan & (cmp_lt | cmp_eq)};
                status_d[fpu_pkg::STATUS_NV] = any_nan; // Signaling compare
            end
            fpu_pkg::CMP_LT: begin
                res_d = {{SB{1'b0}}, ~any_nan & cmp_lt};
                status_d[fpu_pkg::STATUS_NV] = any_nan;
            end
            fpu_pkg::CMP_EQ: begin
                res_d = {{SB{1'b0}}, ~any_nan & cmp_eq};
                status_d[fpu_pkg::STATUS_NV] = any_snan; // Quiet compare
            end
            fpu_pkg::CLASSIFY: res_d = {{(fpu_pkg::FLEN-fpu_pkg::CLASS_BITS){1'b0}}, s1_cls_a_q};
            default: res_d = s1_a_q;
        endcase
    end

    // ----------------------------------------------------------------------
    // Pipeline registers
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin : pipe_valid
        if (!rst_ni) begin
            valid_q <= '0;
        end else if (flush_i) begin
            valid_q <= '0; // Drops in-flight ops and any pulse this cycle
        end else if (!stall) begin
            valid_q <= {valid_q[fpu_pkg::PIPE_DEPTH-2:0], issue_valid_i};
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin : pipe_data
        if (!rst_ni) begin
            s1_op_q     <= fpu_pkg::PASS;
            s1_a_q      <= '0;
            s1_b_q      <= '0;
            s1_cls_a_q  <= '0;
            s1_cls_b_q  <= '0;
            s1_tag_q    <= '0;
            s2_res_q    <= '0;
            s2_status_q <= '0;
            s2_tag_q    <= '0;
        end else if (!stall) begin
            if (issue_valid_i) begin // Stage 1 capture
                s1_op_q    <= nc_op_i;
                s1_a_q     <= operand_a_i;
                s1_b_q     <= operand_b_i;
                s1_cls_a_q <= cls_a;
                s1_cls_b_q <= cls_b;
                s1_tag_q   <= tag_i;
            end
            if (valid_q[0]) begin    // Stage 2 capture
                s2_res_q    <= res_d;
                s2_status_q <= status_d;
                s2_tag_q    <= s1_tag_q;
            end
        end
    end

    assign fpu_valid_o    = valid_q[fpu_pkg::PIPE_DEPTH-1];
    assign result_o       = s2_res_q;
    assign fpu_trans_id_o = s2_tag_q;
    assign fpu_status_o   = s2_status_q;

endmodule

/* source/fpu_wrap.sv */
module fpu_wrap (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 flush_i,
    // From issue
    input  logic                 fpu_valid_i,
    output logic                 fpu_ready_o,
    input  fpu_pkg::fu_op_e      operator_i,
    input  fpu_pkg::rm_t         fpu_rm_i,
    input  fpu_pkg::fp_word_t    operand_a_i,
    input  fpu_pkg::fp_word_t    operand_b_i,
    input  fpu_pkg::trans_id_t   trans_id_i,
    // To writeback
    input  logic                 fpu_ready_i,
    output logic                 fpu_valid_o,
    output fpu_pkg::fp_word_t    result_o,
    output fpu_pkg::trans_id_t   fpu_trans_id_o,
    output fpu_pkg::fp_status_t  fpu_status_o
);

    fpu_pkg::nc_op_e    nc_op_dec;   // Decoder output
    logic               issue_valid;
    logic               issue_ready;
    fpu_pkg::nc_op_e    nc_op;       // Toward the unit
    fpu_pkg::fp_word_t  operand_a;
    fpu_pkg::fp_word_t  operand_b;
    fpu_pkg::trans_id_t tag;

    // ----------------------------------------------------------------------
    // Decode, protocol inversion, execution
    // ----------------------------------------------------------------------
    fp_op_decode u_decode (
        .operator_i (operator_i),
        .fpu_rm_i   (fpu_rm_i),
        .nc_op_o    (nc_op_dec)
    );

    fp_issue_hold u_hold (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .flush_i       (flush_i),
        .fpu_valid_i   (fpu_valid_i),
        .fpu_ready_o   (fpu_ready_o),
        .nc_op_i       (nc_op_dec),
        .operand_a_i   (operand_a_i),
        .operand_b_i   (operand_b_i),
        .trans_id_i    (trans_id_i),
        .issue_ready_i (issue_ready),
        .issue_valid_o (issue_valid),
        .nc_op_o       (nc_op),
        .operand_a_o   (operand_a),
        .operand_b_o   (operand_b),
        .tag_o         (tag)
    );

    // Downstream ready is real back-pressure here
    fp_noncomp_pipe u_pipe (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .flush_i        (flush_i),
        .issue_valid_i  (issue_valid),
        .issue_ready_o  (issue_ready),
        .nc_op_i        (nc_op),
        .operand_a_i    (operand_a),
        .operand_b_i    (operand_b),
        .tag_i          (tag),
        .fpu_ready_i    (fpu_ready_i),
        .fpu_valid_o    (fpu_valid_o),
        .result_o       (result_o),
        .fpu_trans_id_o (fpu_trans_id_o),
        .fpu_status_o   (fpu_status_o)
    );

endmodule

/* sim/tb_fpu_wrap.sv */
module tb_fpu_wrap;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int unsigned MAX_CASES = 64;
    localparam int unsigned SEED      = 32'h9b21f235;
    localparam int          LATENCY   = 2;  // Accepting edge to transfer edge, no back-pressure

    logic                clk_i, rst_ni, flush_i, fpu_valid_i, fpu_ready_i;
    fpu_pkg::fu_op_e     operator_i;
    fpu_pkg::rm_t        fpu_rm_i;
    fpu_pkg::fp_word_t   operand_a_i, operand_b_i;
    fpu_pkg::trans_id_t  trans_id_i;
    logic                fpu_ready_o, fpu_valid_o;
    fpu_pkg::fp_word_t   result_o;
    fpu_pkg::trans_id_t  fpu_trans_id_o;
    fpu_pkg::fp_status_t fpu_status_o;

    // Case table, filled from the cases file
    logic [2:0]          case_op    [MAX_CASES];
    fpu_pkg::rm_t        case_rm    [MAX_CASES];
    fpu_pkg::fp_word_t   case_a     [MAX_CASES];
    fpu_pkg::fp_word_t   case_b     [MAX_CASES];
    fpu_pkg::fp_word_t   case_res   [MAX_CASES];
    fpu_pkg::fp_status_t case_flags [MAX_CASES];
    logic                case_flush [MAX_CASES];
    int                  n_cases = 0;
    bit                  loaded  = 0;

    fpu_pkg::fp_word_t   exp_res_drv;   // Travels with each pulse
    fpu_pkg::fp_status_t exp_flags_drv;
    fpu_pkg::trans_id_t  next_tag;      // Round-robin tags
    logic                bp_phase;      // Random fpu_ready_i when set

    // Scoreboard, in issue order
    fpu_pkg::trans_id_t  q_tag   [$];
    fpu_pkg::fp_word_t   q_res   [$];
    fpu_pkg::fp_status_t q_flags [$];
    int                  q_cycle [$];   // Accepting edge

    int                  errors = 0, checks = 0, cycle = 0, stall_seen = 0;
    logic                held_pending = 1'b0;
    fpu_pkg::fp_word_t   held_res;
    fpu_pkg::trans_id_t  held_tag;
    fpu_pkg::fp_status_t held_flags;

    fpu_wrap dut_i (.*);

    always #50 clk_i = ~clk_i; // 100 ns period

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic load_cases;
        int                  fd;
        int                  n;
        string               line;
        logic [2:0]          op;
        fpu_pkg::rm_t        rm;
        fpu_pkg::fp_word_t   a, b, res;
        fpu_pkg::fp_status_t flags;
        logic                fl;
        fd = $fopen("sim/fpu_cases.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Error: cannot open sim/fpu_cases.txt");
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line[0] != "#" && n_cases < MAX_CASES) begin // Skip notes
                n = $sscanf(line, "%h %h %h %h %h %h %h", op, rm, a, b, res, flags, fl);
                if (n == 7) begin
                    case_op[n_cases]    = op;
                    case_rm[n_cases]    = rm;
                    case_a[n_cases]     = a;
                    case_b[n_cases]     = b;
                    case_res[n_cases]   = res;
                    case_flags[n_cases] = flags;
                    case_flush[n_cases] = fl;
                    n_cases++;
                end
            end
        end
        $fclose(fd);
    endtask

    // ----------------------------------------------------------------------
    // Issue side driver
    // ----------------------------------------------------------------------
    task automatic drive_pass;
        for (int i = 0; i < n_cases; i++) begin
            @(posedge clk_i);
            while (!fpu_ready_o) begin // Core waits for a ready cycle
                fpu_valid_i <= 1'b0;
                @(posedge clk_i);
            end
            fpu_valid_i   <= 1'b1;
            operator_i    <= fpu_pkg::fu_op_e'(case_op[i]);
            fpu_rm_i      <= case_rm[i];
            operand_a_i   <= case_a[i];
            operand_b_i   <= case_b[i];
            trans_id_i    <= next_tag;
            exp_res_drv   <= case_res[i];
            exp_flags_drv <= case_flags[i];
            next_tag = next_tag + 1'b1;
            if (case_flush[i]) begin   // Kill this op and whatever is behind it
                @(posedge clk_i);
                fpu_valid_i <= 1'b0;
                flush_i     <= 1'b1;
                @(posedge clk_i);
                flush_i     <= 1'b0;
            end
        end
        @(posedge clk_i);
        fpu_valid_i <= 1'b0;
    endtask

    task automatic wait_drain;
        while (q_tag.size() != 0) @(negedge clk_i); // Queue settles after each edge
        repeat (4) @(posedge clk_i); // Room for stray outputs
    endtask

    initial begin : main
        clk_i         = 1'b0;
        rst_ni        = 1'b0;
        flush_i       = 1'b0;
        fpu_valid_i   = 1'b0;
        operator_i    = fpu_pkg::FSGNJ;
        fpu_rm_i      = '0;
        operand_a_i   = '0;
        operand_b_i   = '0;
        trans_id_i    = '0;
        exp_res_drv   = '0;
        exp_flags_drv = '0;
        next_tag      = '0;
        bp_phase      = 1'b0;
        load_cases();
        loaded = 1'b1;
        repeat (2) @(posedge clk_i);
        rst_ni <= 1'b1;
        drive_pass();              // Writeback always ready
        wait_drain();
        @(posedge clk_i);
        bp_phase <= 1'b1;
        drive_pass();              // Same cases under back-pressure
        wait_drain();
        if (stall_seen == 0) begin
            errors++;
            $display("Error: fpu_ready_o never went low under back-pressure");
        end
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

    initial begin : ready_gen
        int unsigned seed_ret;
        fpu_ready_i = 1'b1;
        seed_ret    = $urandom(SEED);
        forever begin
            @(posedge clk_i);
            if (bp_phase) fpu_ready_i <= ($urandom % 100) >= 30; // Low ~30 %
            else          fpu_ready_i <= 1'b1;
        end
    end

    // ----------------------------------------------------------------------
    // Scoreboard and output monitor
    // ----------------------------------------------------------------------
    always @(posedge clk_i) begin : scoreboard
        int acc;
        if (rst_ni) begin
            cycle++;
            if (!bp_phase) check_value("fpu_ready_o", fpu_ready_o, 1'b1); // Unit never busy
            if (held_pending) begin // Output must not move while stalled
                check_value("fpu_valid_o (held)", fpu_valid_o, 1'b1);
                check_value("result_o (held)", result_o, held_res);
                check_value("fpu_trans_id_o (held)", fpu_trans_id_o, held_tag);
                check_value("fpu_status_o (held)", fpu_status_o, held_flags);
            end
            held_pending = fpu_valid_o && !fpu_ready_i && !flush_i;
            held_res     = result_o;
            held_tag     = fpu_trans_id_o;
            held_flags   = fpu_status_o;
            if (fpu_valid_o && fpu_ready_i) begin
                if (q_tag.size() == 0) begin
                    errors++;
                    $display("Error at %0t ns: result with tag %0d but nothing pending",
                             $time, fpu_trans_id_o);
                end else begin
                    check_value("fpu_trans_id_o", fpu_trans_id_o, q_tag.pop_front());
                    check_value("result_o", result_o, q_res.pop_front());
                    check_value("fpu_status_o", fpu_status_o, q_flags.pop_front());
                    acc = q_cycle.pop_front();
                    if (!bp_phase) check_value("latency", cycle - acc, LATENCY);
                end
            end
            if (flush_i) begin      // Everything in flight is gone
                q_tag.delete();
                q_res.delete();
                q_flags.delete();
                q_cycle.delete();
            end
            if (fpu_valid_i) begin  // Pulse is always taken
                q_tag.push_back(trans_id_i);
                q_res.push_back(exp_res_drv);
                q_flags.push_back(exp_flags_drv);
                q_cycle.push_back(cycle);
            end
            if (bp_phase && !fpu_ready_o) stall_seen++;
        end
    end

    initial begin : watchdog
        wait (loaded);
        repeat (n_cases * 20 + 50) @(posedge clk_i);
        $display("Timeout: run did not finish within %0d clock periods", n_cases * 20 + 50);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

/* src.f */
source/fpu_pkg.sv
source/fp_op_decode.sv
source/fp_issue_hold.sv
source/fp_operand_class.sv
source/fp_noncomp_pipe.sv
source/fpu_wrap.sv
sim/tb_fpu_wrap.sv

/* sim/fpu_cases.txt */
# op rm operand_a operand_b result flags flush  (all hex, flags 10 = NV)
# op 0 sgnj, 1 min/max, 2 cmp, 3 class, 4 fmv.x.w, 5 fmv.w.x; flush 1 pulses flush_i after op
0 4 3f800000 c0000000 bf800000 00 0
0 1 3f800000 c0000000 3f800000 00 0
0 2 bf800000 c0000000 3f800000 00 0
0 3 c0a00000 00000000 c0a00000 00 0
4 0 12345678 00000000 12345678 00 0
5 0 deadbeef 00000000 deadbeef 00 0
1 0 c0000000 bf800000 c0000000 00 0
1 1 80000000 00000000 00000000 00 0
1 0 80000000 00000000 80000000 00 0
1 0 7fc00000 c0400000 c0400000 00 0
1 1 7f800001 3f800000 3f800000 10 0
1 0 7fc00000 7f800001 7fc00000 10 0
2 0 00000000 80000000 00000001 00 0
2 1 c0000000 3f800000 00000001 00 0
2 1 7fc00000 3f800000 00000000 10 0
2 2 7fc00000 3f800000 00000000 00 0
2 2 7f800001 3f800000 00000000 10 0
0 0 40490fdb 80000000 c0490fdb 00 1
3 0 ff800000 00000000 00000001 00 0
3 0 c0000000 00000000 00000002 00 0
3 0 807fffff 00000000 00000004 00 0
3 0 80000000 00000000 00000008 00 0
3 0 00000001 00000000 00000020 00 0
3 0 7f800000 00000000 00000080 00 0
3 0 7f800001 00000000 00000100 00 0
3 0 7fc00000 00000000 00000200 00 0
